// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define XLEN      32
`define REG_AW    5
`define RESET_PC  32'h0000_0000
`define NOP_INSTR 32'h0000_0013       // addi x0, x0, 0

// major opcodes
`define OPCODE_OP      7'b0110011
`define OPCODE_OP_IMM  7'b0010011
`define OPCODE_LUI     7'b0110111
`define OPCODE_LOAD    7'b0000011
`define OPCODE_STORE   7'b0100011
`define OPCODE_BRANCH  7'b1100011

// funct3 codes
`define F3_ADD   3'b000                // add, sub, addi
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SRL   3'b101                // srl and sra
`define F3_OR    3'b110
`define F3_AND   3'b111
`define F3_LW    3'b010
`define F3_SW    3'b010
`define F3_BEQ   3'b000
`define F3_BNE   3'b001

// funct7 codes
`define F7_BASE  7'b0000000
`define F7_ALT   7'b0100000            // sub, sra

`endif

// File: verilog/core_pkg.sv
`include "core_params.svh"

package core_pkg;

  typedef logic [`XLEN-1:0]   word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  typedef enum logic [6:0] {
    OPC_OP     = `OPCODE_OP,
    OPC_OP_IMM = `OPCODE_OP_IMM,
    OPC_LUI    = `OPCODE_LUI,
    OPC_LOAD   = `OPCODE_LOAD,
    OPC_STORE  = `OPCODE_STORE,
    OPC_BRANCH = `OPCODE_BRANCH
  } opcode_e;

  // ALU_ADD is zero so an all-zero ctrl is a harmless add
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE
  } branch_e;

  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wb_src_e;

  // all zero is a bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;    // operand b is the immediate
    logic    zero_a;     // operand a is zero
    logic    mem_read;
    logic    mem_write;
    wb_src_e wb_src;
    logic    reg_write;
  } ctrl_t;

endpackage

// File: verilog/pipe_if.sv
`timescale 1ns/10ps

// decode to execute pipeline register
interface id_ex_if;
  core_pkg::ctrl_t     ctrl;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     imm;
  core_pkg::reg_addr_t rd;

  modport src (output ctrl, rs1, rs2, rs1_data, rs2_data, imm, rd);
  modport dst (input  ctrl, rs1, rs2, rs1_data, rs2_data, imm, rd);
endinterface

// execute to memory pipeline register
interface ex_mem_if;
  core_pkg::ctrl_t     ctrl;
  core_pkg::word_t     alu_out;
  core_pkg::word_t     store_data;
  core_pkg::reg_addr_t rd;

  modport src (output ctrl, alu_out, store_data, rd);
  modport dst (input  ctrl, alu_out, store_data, rd);
endinterface

// forwarding bus, write flags are already low for x0
interface fwd_if;
  logic ex_we, mem_we, wb_we;
  core_pkg::reg_addr_t ex_rd, mem_rd, wb_rd;
  core_pkg::word_t ex_data, mem_data, wb_data;

  modport ex_src  (output ex_we, ex_rd, ex_data);
  modport mem_src (output mem_we, mem_rd, mem_data, wb_we, wb_rd, wb_data);
  modport sink    (input  ex_we, ex_rd, ex_data, mem_we, mem_rd, mem_data,
                          wb_we, wb_rd, wb_data);
endinterface

// File: verilog/fetch_stage.sv
`timescale 1ns/10ps
`include "core_params.svh"

module fetch_stage (
  input  logic            CLK,
  input  logic            rst,
  input  logic            stall,
  input  logic            redirect,
  input  core_pkg::word_t target,
  output core_pkg::word_t i_mem_addr,
  input  core_pkg::word_t i_mem_rdata,
  output core_pkg::word_t if_id_instr,
  output core_pkg::word_t if_id_pc
);

  core_pkg::word_t pc;

  assign i_mem_addr = pc;

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      pc          <= `RESET_PC;
      if_id_instr <= `NOP_INSTR;
    end
    else if (redirect)
    begin
      pc          <= target;
      if_id_instr <= `NOP_INSTR;     // squash the wrong-path fetch
      if_id_pc    <= pc;
    end
    else if (!stall)
    begin
      pc          <= pc + 32'd4;
      if_id_instr <= i_mem_rdata;
      if_id_pc    <= pc;
    end
  end

  // decode must never ask for both at once
  a_no_stall_redirect: assert property (@(posedge CLK) disable iff (rst)
    !(stall && redirect))
    else $error("fetch got stall and redirect in the same cycle");

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps
`include "core_params.svh"

module instr_decoder (
  input  core_pkg::word_t   instr,
  output core_pkg::ctrl_t   ctrl,
  output core_pkg::branch_e branch,
  output core_pkg::word_t   imm,
  output logic              uses_rs2
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  core_pkg::word_t imm_i, imm_s, imm_b, imm_u;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // shared by register and immediate forms, only the register form has sub
  function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                input logic is_reg);
    core_pkg::alu_op_e op;
    case (f3)
      `F3_ADD:  op = (is_reg && alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      `F3_SLL:  op = core_pkg::ALU_SLL;
      `F3_SLT:  op = core_pkg::ALU_SLT;
      `F3_SLTU: op = core_pkg::ALU_SLTU;
      `F3_XOR:  op = core_pkg::ALU_XOR;
      `F3_SRL:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      `F3_OR:   op = core_pkg::ALU_OR;
      default:  op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb
  begin
    ctrl     = '0;              // unknown opcodes stay a bubble
    branch   = core_pkg::BR_NONE;
    imm      = '0;
    uses_rs2 = 1'b0;
    case (core_pkg::opcode_e'(instr[6:0]))
      core_pkg::OPC_OP:
      begin
        ctrl.alu_op    = alu_sel(funct3, funct7 == `F7_ALT, 1'b1);
        ctrl.reg_write = 1'b1;
        uses_rs2       = 1'b1;
      end
      core_pkg::OPC_OP_IMM:
      begin
        ctrl.alu_op    = alu_sel(funct3, funct7 == `F7_ALT, 1'b0);
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_i;
      end
      core_pkg::OPC_LUI:
      begin
        ctrl.alu_op    = core_pkg::ALU_PASS_B;
        ctrl.use_imm   = 1'b1;
        ctrl.zero_a    = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = imm_u;
      end
      core_pkg::OPC_LOAD:
        if (funct3 == `F3_LW)
        begin
          ctrl.use_imm   = 1'b1;    // address = rs1 + imm
          ctrl.mem_read  = 1'b1;
          ctrl.wb_src    = core_pkg::WB_MEM;
          ctrl.reg_write = 1'b1;
          imm            = imm_i;
        end
      core_pkg::OPC_STORE:
        if (funct3 == `F3_SW)
        begin
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
          imm            = imm_s;
          uses_rs2       = 1'b1;    // store data
        end
      core_pkg::OPC_BRANCH:
        if (funct3 == `F3_BEQ || funct3 == `F3_BNE)
        begin
          branch   = (funct3 == `F3_BEQ) ? core_pkg::BR_EQ : core_pkg::BR_NE;
          imm      = imm_b;
          uses_rs2 = 1'b1;
        end
      default: ;
    endcase
  end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                CLK,
  input  logic                rst,
  input  core_pkg::word_t     if_id_instr,
  input  core_pkg::word_t     if_id_pc,
  output core_pkg::reg_addr_t rf_ra1,
  output core_pkg::reg_addr_t rf_ra2,
  input  core_pkg::word_t     rf_rd1,
  input  core_pkg::word_t     rf_rd2,
  output logic                stall,
  output logic                redirect,
  output core_pkg::word_t     target,
  fwd_if.sink                 fwd,
  id_ex_if.src                id_ex
);

  core_pkg::ctrl_t     ctrl;
  core_pkg::branch_e   branch;
  core_pkg::word_t     imm;
  logic                uses_rs1, uses_rs2;
  core_pkg::reg_addr_t rs1, rs2, rd;
  core_pkg::word_t     rs1_val, rs2_val;
  logic                taken;

  instr_decoder u_dec (
    .instr    (if_id_instr),
    .ctrl     (ctrl),
    .branch   (branch),
    .imm      (imm),
    .uses_rs2 (uses_rs2)
  );

  assign rs1 = if_id_instr[19:15];
  assign rs2 = if_id_instr[24:20];
  assign rd  = if_id_instr[11:7];

  assign rf_ra1 = rs1;
  assign rf_ra2 = rs2;

  assign uses_rs1 = !ctrl.zero_a;  // only lui ignores rs1

  // newest producer wins
  function automatic core_pkg::word_t fwd_pick(input core_pkg::reg_addr_t ra,
                                               input core_pkg::word_t rf_val);
    if (fwd.ex_we && fwd.ex_rd == ra)
      return fwd.ex_data;
    else if (fwd.mem_we && fwd.mem_rd == ra)
      return fwd.mem_data;
    else if (fwd.wb_we && fwd.wb_rd == ra)
      return fwd.wb_data;
    return rf_val;
  endfunction

  assign rs1_val = fwd_pick(rs1, rf_rd1);
  assign rs2_val = fwd_pick(rs2, rf_rd2);

  // a load in execute has only its address on the ex slot
  assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                 ((uses_rs1 && id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

  always_comb
  begin
    case (branch)
      core_pkg::BR_EQ: taken = (rs1_val == rs2_val);
      core_pkg::BR_NE: taken = (rs1_val != rs2_val);
      default:         taken = 1'b0;
    endcase
  end

  assign redirect = taken && !stall;    // operands not valid yet while stalled
  assign target   = if_id_pc + imm;

  always_ff @(posedge CLK)
  begin
    if (rst || stall)
      id_ex.ctrl <= '0;
    else
      id_ex.ctrl <= ctrl;
    id_ex.rs1      <= rs1;
    id_ex.rs2      <= rs2;
    id_ex.rs1_data <= rs1_val;
    id_ex.rs2_data <= rs2_val;
    id_ex.imm      <= imm;
    id_ex.rd       <= rd;
  end

  a_stall_excl_redirect: assert property (@(posedge CLK) disable iff (rst)
    !(redirect && stall))
    else $error("redirect while stalled");

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic  CLK,
  input  logic  rst,
  id_ex_if.dst  id_ex,
  fwd_if.ex_src fwd,
  fwd_if.sink   fwd_in,
  ex_mem_if.src ex_mem
);

  core_pkg::word_t rs1_val, rs2_val;
  core_pkg::word_t op_a, op_b;
  core_pkg::word_t alu_out;

  // the ex slot was already applied in decode
  function automatic core_pkg::word_t fwd_pick(input core_pkg::reg_addr_t ra,
                                               input core_pkg::word_t id_val);
    if (fwd_in.mem_we && fwd_in.mem_rd == ra)
      return fwd_in.mem_data;
    else if (fwd_in.wb_we && fwd_in.wb_rd == ra)
      return fwd_in.wb_data;
    return id_val;
  endfunction

  assign rs1_val = fwd_pick(id_ex.rs1, id_ex.rs1_data);
  assign rs2_val = fwd_pick(id_ex.rs2, id_ex.rs2_data);

  assign op_a = id_ex.ctrl.zero_a  ? '0        : rs1_val;
  assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;

  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      core_pkg::ALU_ADD:    alu_out = op_a + op_b;
      core_pkg::ALU_SUB:    alu_out = op_a - op_b;
      core_pkg::ALU_AND:    alu_out = op_a & op_b;
      core_pkg::ALU_OR:     alu_out = op_a | op_b;
      core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      core_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
      core_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
      core_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
      core_pkg::ALU_SLT:    alu_out = core_pkg::word_t'($signed(op_a) < $signed(op_b));
      core_pkg::ALU_SLTU:   alu_out = core_pkg::word_t'(op_a < op_b);
      core_pkg::ALU_PASS_B: alu_out = op_b;
      default:              alu_out = '0;
    endcase
  end

  assign fwd.ex_we   = id_ex.ctrl.reg_write && (id_ex.rd != '0);
  assign fwd.ex_rd   = id_ex.rd;
  assign fwd.ex_data = alu_out;

  always_ff @(posedge CLK)
  begin
    if (rst)
      ex_mem.ctrl <= '0;
    else
      ex_mem.ctrl <= id_ex.ctrl;
    ex_mem.alu_out    <= alu_out;   // memory address for lw and sw
    ex_mem.store_data <= rs2_val;
    ex_mem.rd         <= id_ex.rd;
  end

  a_rw_exclusive: assert property (@(posedge CLK) disable iff (rst)
    !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write))
    else $error("instruction marked as both load and store");

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage (
  input  logic                CLK,
  input  logic                rst,
  ex_mem_if.dst               ex_mem,
  output logic                d_mem_en,
  output logic                d_mem_we,
  output core_pkg::word_t     d_mem_addr,
  output core_pkg::word_t     d_mem_wdata,
  input  core_pkg::word_t     d_mem_rdata,
  fwd_if.mem_src              fwd,
  output logic                rf_we,
  output core_pkg::reg_addr_t rf_wa,
  output core_pkg::word_t     rf_wd
);

  logic                wb_reg_write;
  core_pkg::wb_src_e   wb_src;
  core_pkg::reg_addr_t wb_rd;
  core_pkg::word_t     wb_alu, wb_load;

  assign d_mem_en    = ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write;
  assign d_mem_we    = ex_mem.ctrl.mem_write;
  assign d_mem_addr  = ex_mem.alu_out;
  assign d_mem_wdata = ex_mem.store_data;

  // load data is already valid here, memory answers in the same cycle
  assign fwd.mem_we   = ex_mem.ctrl.reg_write && (ex_mem.rd != '0);
  assign fwd.mem_rd   = ex_mem.rd;
  assign fwd.mem_data = (ex_mem.ctrl.wb_src == core_pkg::WB_MEM) ? d_mem_rdata
                                                                 : ex_mem.alu_out;

  always_ff @(posedge CLK)
  begin
    if (rst)
      wb_reg_write <= 1'b0;
    else
      wb_reg_write <= ex_mem.ctrl.reg_write;
    wb_src  <= ex_mem.ctrl.wb_src;
    wb_rd   <= ex_mem.rd;
    wb_alu  <= ex_mem.alu_out;
    wb_load <= d_mem_rdata;
  end

  assign rf_we = wb_reg_write && (wb_rd != '0);   // x0 stays zero
  assign rf_wa = wb_rd;
  assign rf_wd = (wb_src == core_pkg::WB_MEM) ? wb_load : wb_alu;

  assign fwd.wb_we   = rf_we;
  assign fwd.wb_rd   = wb_rd;
  assign fwd.wb_data = rf_wd;

  a_we_needs_en: assert property (@(posedge CLK) disable iff (rst)
    d_mem_we |-> d_mem_en)
    else $error("data memory write without enable");

endmodule

// File: verilog/riscv_top.sv
`timescale 1ns/10ps

module riscv_top (
  input  logic                CLK,
  input  logic                rst,
  // instruction memory
  output core_pkg::word_t     i_mem_addr,
  input  core_pkg::word_t     i_mem_rdata,
  // data memory
  output logic                d_mem_en,
  output logic                d_mem_we,
  output core_pkg::word_t     d_mem_addr,
  output core_pkg::word_t     d_mem_wdata,
  input  core_pkg::word_t     d_mem_rdata,
  // register file
  output core_pkg::reg_addr_t rf_ra1,
  output core_pkg::reg_addr_t rf_ra2,
  output core_pkg::reg_addr_t rf_wa,
  input  core_pkg::word_t     rf_rd1,
  input  core_pkg::word_t     rf_rd2,
  output logic                rf_we,
  output core_pkg::word_t     rf_wd
);

  core_pkg::word_t if_id_instr, if_id_pc;
  core_pkg::word_t target;
  logic            stall, redirect;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  fwd_if    fwd_bus ();

  fetch_stage u_fetch (
    .CLK         (CLK),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .target      (target),
    .i_mem_addr  (i_mem_addr),
    .i_mem_rdata (i_mem_rdata),
    .if_id_instr (if_id_instr),
    .if_id_pc    (if_id_pc)
  );

  decode_stage u_decode (
    .CLK         (CLK),
    .rst         (rst),
    .if_id_instr (if_id_instr),
    .if_id_pc    (if_id_pc),
    .rf_ra1      (rf_ra1),
    .rf_ra2      (rf_ra2),
    .rf_rd1      (rf_rd1),
    .rf_rd2      (rf_rd2),
    .stall       (stall),
    .redirect    (redirect),
    .target      (target),
    .fwd         (fwd_bus),
    .id_ex       (id_ex)
  );

  // execute drives its own slot and reads the later ones
  execute_stage u_execute (
    .CLK    (CLK),
    .rst    (rst),
    .id_ex  (id_ex),
    .fwd    (fwd_bus),
    .fwd_in (fwd_bus),
    .ex_mem (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .CLK         (CLK),
    .rst         (rst),
    .ex_mem      (ex_mem),
    .d_mem_en    (d_mem_en),
    .d_mem_we    (d_mem_we),
    .d_mem_addr  (d_mem_addr),
    .d_mem_wdata (d_mem_wdata),
    .d_mem_rdata (d_mem_rdata),
    .fwd         (fwd_bus),
    .rf_we       (rf_we),
    .rf_wa       (rf_wa),
    .rf_wd       (rf_wd)
  );

endmodule

// File: verification/core_tb.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_tb;

  localparam int N_TESTS      = 6;
  localparam int MAX_PROG     = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RUN_CYCLES   = 30;
  localparam int WATCHDOG_NS  = N_TESTS * (RESET_CYCLES + RUN_CYCLES) * 10 * 2;

  logic                CLK = 1'b0;
  logic                rst;
  core_pkg::word_t     i_mem_addr, i_mem_rdata;
  logic                d_mem_en, d_mem_we;
  core_pkg::word_t     d_mem_addr, d_mem_wdata, d_mem_rdata;
  core_pkg::reg_addr_t rf_ra1, rf_ra2, rf_wa;
  core_pkg::word_t     rf_rd1, rf_rd2, rf_wd;
  logic                rf_we;

  core_pkg::word_t imem [64];
  core_pkg::word_t dmem [64];
  core_pkg::word_t regs [32];

  // one row per test, expected writes in program order
  string               test_name   [N_TESTS];
  core_pkg::word_t     prog        [N_TESTS][MAX_PROG];
  int                  prog_len    [N_TESTS];
  core_pkg::reg_addr_t exp_wa      [N_TESTS][MAX_PROG];
  core_pkg::word_t     exp_wd      [N_TESTS][MAX_PROG];
  int                  n_wr        [N_TESTS];
  bit                  has_store   [N_TESTS];
  core_pkg::word_t     exp_st_addr [N_TESTS];
  core_pkg::word_t     exp_st_data [N_TESTS];

  core_pkg::reg_addr_t got_wa [$];   // seen on the write port
  core_pkg::word_t     got_wd [$];
  core_pkg::word_t     got_st_addr [$];
  core_pkg::word_t     got_st_data [$];

  riscv_top UUT (
    .CLK         (CLK),
    .rst         (rst),
    .i_mem_addr  (i_mem_addr),
    .i_mem_rdata (i_mem_rdata),
    .d_mem_en    (d_mem_en),
    .d_mem_we    (d_mem_we),
    .d_mem_addr  (d_mem_addr),
    .d_mem_wdata (d_mem_wdata),
    .d_mem_rdata (d_mem_rdata),
    .rf_ra1      (rf_ra1),
    .rf_ra2      (rf_ra2),
    .rf_wa       (rf_wa),
    .rf_rd1      (rf_rd1),
    .rf_rd2      (rf_rd2),
    .rf_we       (rf_we),
    .rf_wd       (rf_wd)
  );

  always #5 CLK = ~CLK;

  assign i_mem_rdata = (i_mem_addr[31:8] == 24'd0) ? imem[i_mem_addr[7:2]] : `NOP_INSTR;
  assign d_mem_rdata = d_mem_en ? dmem[d_mem_addr[7:2]] : '0;   // no data unless enabled
  assign rf_rd1      = regs[rf_ra1];
  assign rf_rd2      = regs[rf_ra2];

  // register file and data memory come back to their start values during reset
  always @(posedge CLK)
  begin
    if (rst)
    begin
      for (int k = 0; k < 32; k++)
        regs[k] <= core_pkg::word_t'(16 * k);
      for (int k = 0; k < 64; k++)
        dmem[k] <= core_pkg::word_t'(1000 + k);
    end
    else
    begin
      if (rf_we && rf_wa != '0)
        regs[rf_wa] <= rf_wd;
      if (d_mem_en && d_mem_we)
        dmem[d_mem_addr[7:2]] <= d_mem_wdata;
    end
  end

  function automatic core_pkg::word_t r_type(input logic [6:0] f7, input int rs2,
                                             input int rs1, input logic [2:0] f3,
                                             input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPCODE_OP};
  endfunction

  function automatic core_pkg::word_t i_type(input int imm, input int rs1,
                                             input logic [2:0] f3, input int rd,
                                             input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic core_pkg::word_t s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], `F3_SW, imm[4:0], `OPCODE_STORE};
  endfunction

  // imm is the byte offset from the branch itself
  function automatic core_pkg::word_t b_type(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPCODE_BRANCH};
  endfunction

  function automatic core_pkg::word_t u_type(input int imm, input int rd);
    return {imm[19:0], rd[4:0], `OPCODE_LUI};
  endfunction

  // rd of 0 means the instruction must not show up on the write port
  task automatic add_step(input int t, input core_pkg::word_t instr, input int rd,
                          input core_pkg::word_t value);
    prog[t][prog_len[t]] = instr;
    prog_len[t]++;
    if (rd != 0)
    begin
      exp_wa[t][n_wr[t]] = rd[4:0];
      exp_wd[t][n_wr[t]] = value;
      n_wr[t]++;
    end
  endtask

  task automatic expect_store(input int t, input core_pkg::word_t addr,
                              input core_pkg::word_t data);
    has_store[t]   = 1'b1;
    exp_st_addr[t] = addr;
    exp_st_data[t] = data;
  endtask

  task automatic build_table;
    for (int t = 0; t < N_TESTS; t++)
    begin
      prog_len[t]  = 0;
      n_wr[t]      = 0;
      has_store[t] = 1'b0;
    end
    // xk starts at 16*k, data word k at 1000+k
    test_name[0] = "alu_chain";
    add_step(0, i_type(5, 0, `F3_ADD, 1, `OPCODE_OP_IMM), 1, 5);
    add_step(0, r_type(`F7_BASE, 1, 1, `F3_ADD, 2), 2, 10);
    add_step(0, r_type(`F7_ALT, 1, 2, `F3_ADD, 3), 3, 5);
    add_step(0, r_type(`F7_BASE, 2, 3, `F3_XOR, 4), 4, 15);
    add_step(0, r_type(`F7_BASE, 2, 4, `F3_SLL, 5), 5, 15360);     // x2 from writeback
    add_step(0, r_type(`F7_ALT, 5, 0, `F3_ADD, 6), 6, 32'hffff_c400);
    add_step(0, r_type(`F7_ALT, 3, 6, `F3_SRL, 7), 7, 32'hffff_fe20);
    add_step(0, r_type(`F7_BASE, 1, 7, `F3_SLT, 8), 8, 1);

    test_name[1] = "lui_const";
    add_step(1, u_type('h12345, 9), 9, 32'h1234_5000);
    add_step(1, i_type('h678, 9, `F3_ADD, 9, `OPCODE_OP_IMM), 9, 32'h1234_5678);
    add_step(1, i_type(1, 9, `F3_ADD, 0, `OPCODE_OP_IMM), 0, 0);   // x0 target
    add_step(1, r_type(`F7_BASE, 9, 0, `F3_ADD, 10), 10, 32'h1234_5678);
    add_step(1, u_type('habcde, 11), 11, 32'habcd_e000);
    add_step(1, i_type(-1, 11, `F3_ADD, 11, `OPCODE_OP_IMM), 11, 32'habcd_dfff);

    test_name[2] = "load_use";
    add_step(2, i_type(8, 0, `F3_LW, 1, `OPCODE_LOAD), 1, 1002);
    add_step(2, r_type(`F7_BASE, 3, 1, `F3_ADD, 2), 2, 1050);
    add_step(2, i_type(16, 0, `F3_ADD, 5, `OPCODE_OP_IMM), 5, 16);
    add_step(2, i_type(0, 5, `F3_LW, 6, `OPCODE_LOAD), 6, 1004);
    add_step(2, r_type(`F7_ALT, 5, 6, `F3_ADD, 7), 7, 988);
    add_step(2, r_type(`F7_BASE, 7, 2, `F3_ADD, 8), 8, 2038);

    test_name[3] = "store_fwd";
    add_step(3, i_type('h55, 0, `F3_ADD, 1, `OPCODE_OP_IMM), 1, 'h55);
    add_step(3, s_type(12, 1, 4), 0, 0);                            // x4 = 64
    add_step(3, i_type(76, 0, `F3_LW, 2, `OPCODE_LOAD), 2, 'h55);
    add_step(3, r_type(`F7_BASE, 2, 2, `F3_ADD, 3), 3, 'haa);
    expect_store(3, 76, 'h55);

    test_name[4] = "branch_taken";
    add_step(4, i_type(7, 0, `F3_ADD, 1, `OPCODE_OP_IMM), 1, 7);
    add_step(4, i_type(7, 0, `F3_ADD, 2, `OPCODE_OP_IMM), 2, 7);
    add_step(4, b_type(12, 2, 1, `F3_BEQ), 0, 0);
    add_step(4, i_type(1, 0, `F3_ADD, 3, `OPCODE_OP_IMM), 0, 0);   // skipped
    add_step(4, i_type(1, 0, `F3_ADD, 4, `OPCODE_OP_IMM), 0, 0);   // skipped
    add_step(4, b_type(8, 2, 1, `F3_BNE), 0, 0);                    // falls through
    add_step(4, i_type(9, 0, `F3_ADD, 5, `OPCODE_OP_IMM), 5, 9);
    add_step(4, i_type(1, 5, `F3_ADD, 6, `OPCODE_OP_IMM), 6, 10);

    test_name[5] = "branch_load";
    add_step(5, i_type(1000, 0, `F3_ADD, 2, `OPCODE_OP_IMM), 2, 1000);
    add_step(5, i_type(0, 0, `F3_LW, 1, `OPCODE_LOAD), 1, 1000);
    add_step(5, b_type(12, 2, 1, `F3_BEQ), 0, 0);
    add_step(5, i_type(3, 0, `F3_ADD, 3, `OPCODE_OP_IMM), 0, 0);
    add_step(5, i_type(4, 0, `F3_ADD, 4, `OPCODE_OP_IMM), 0, 0);
    add_step(5, i_type(4, 0, `F3_LW, 5, `OPCODE_LOAD), 5, 1001);
    add_step(5, b_type(8, 2, 5, `F3_BNE), 0, 0);                    // jumps past the end
    add_step(5, i_type(6, 0, `F3_ADD, 6, `OPCODE_OP_IMM), 0, 0);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_reg_write(input string name, input int idx,
                                 input core_pkg::reg_addr_t exp_a, input core_pkg::word_t exp_d,
                                 input core_pkg::reg_addr_t act_a, input core_pkg::word_t act_d);
    if (exp_a !== act_a || exp_d !== act_d)
      abort_run($sformatf("MISMATCH %s write %0d: expected x%0d = %h, actual x%0d = %h",
                          name, idx, exp_a, exp_d, act_a, act_d));
  endtask

  task automatic check_store(input string name, input string field,
                             input core_pkg::word_t exp_v, input core_pkg::word_t act_v);
    if (exp_v !== act_v)
      abort_run($sformatf("MISMATCH %s %s: expected %h, actual %h", name, field, exp_v, act_v));
  endtask

  task automatic check_count(input string name, input string what, input int exp_n,
                             input int act_n);
    if (exp_n != act_n)
      abort_run($sformatf("MISMATCH %s %s count: expected %0d, actual %0d",
                          name, what, exp_n, act_n));
  endtask

  task automatic expect_idle(input string name);
    if (rf_we !== 1'b0 || d_mem_en !== 1'b0)
      abort_run($sformatf("%s: register or memory access enabled during or right after reset",
                          name));
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < 64; i++)
    begin
      if (i < prog_len[t])
        imem[i] = prog[t][i];
      else
        imem[i] = `NOP_INSTR;
    end
  endtask

  // entered and left on a falling edge
  task automatic run_test(input int t);
    load_program(t);
    rst = 1'b1;
    repeat (RESET_CYCLES)
    begin
      @(negedge CLK);
      expect_idle(test_name[t]);
    end
    rst = 1'b0;
    got_wa.delete();
    got_wd.delete();
    got_st_addr.delete();
    got_st_data.delete();
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
    begin
      @(negedge CLK);
      if (cyc == 0)
        expect_idle(test_name[t]);
      if (rf_we)
      begin
        got_wa.push_back(rf_wa);
        got_wd.push_back(rf_wd);
      end
      if (d_mem_we)
      begin
        got_st_addr.push_back(d_mem_addr);
        got_st_data.push_back(d_mem_wdata);
      end
    end
    check_count(test_name[t], "register write", n_wr[t], got_wa.size());
    for (int i = 0; i < n_wr[t]; i++)
      check_reg_write(test_name[t], i, exp_wa[t][i], exp_wd[t][i], got_wa[i], got_wd[i]);
    check_count(test_name[t], "store", has_store[t] ? 1 : 0, got_st_addr.size());
    if (has_store[t])
    begin
      check_store(test_name[t], "store address", exp_st_addr[t], got_st_addr[0]);
      check_store(test_name[t], "store data", exp_st_data[t], got_st_data[0]);
    end
  endtask

  // reset hits while a register write and a store are in flight
  task automatic reset_in_flight(input int t);
    load_program(t);
    rst = 1'b1;
    repeat (RESET_CYCLES)
      @(negedge CLK);
    rst = 1'b0;
    repeat (4)
      @(negedge CLK);
    if (rf_we !== 1'b1 || d_mem_en !== 1'b1)
      abort_run("pipeline had no register write and memory access in flight before reset");
    rst = 1'b1;
    repeat (RESET_CYCLES)
    begin
      @(negedge CLK);
      expect_idle("reset_in_flight");
    end
    rst = 1'b0;
    @(negedge CLK);
    expect_idle("reset_in_flight");
  endtask

  initial
  begin
    rst = 1'b1;
    build_table();
    for (int i = 0; i < 64; i++)
      imem[i] = `NOP_INSTR;
    @(negedge CLK);
    for (int t = 0; t < N_TESTS; t++)
      run_test(t);
    reset_in_flight(3);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $fatal(1);
  end

endmodule

// File: sim.f
+incdir+include
verilog/core_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/instr_decoder.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_top.sv
verification/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module core_tb \
  -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/core_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
